// File: Bender.yml
package:
  name: core_glue

export_include_dirs:
  - common

sources:
  - common/core_pkg.sv
  - design/reset_stretch.sv
  - design/cache_warmup.sv
  - mem_steer/mem_op_decode.sv
  - mem_steer/mem_req_router.sv
  - design/wb_trace.sv
  - design/core_glue_top.sv
  - target: test
    files:
      - verification/core_glue_tb.sv

// File: common/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths and counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define XLEN                  32
`define REG_ID_W              5
`define RESET_HOLD_CYCLES     128 // cycles the caches need to clear their tags
`define ICACHE_WARMUP_FETCHES 3

// top three bits of a kseg1 virtual address
`define KSEG1_PREFIX          3'b101

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// major opcodes of the memory instructions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define OP_LB    6'h20
`define OP_LH    6'h21
`define OP_LW    6'h23
`define OP_LBU   6'h24
`define OP_LHU   6'h25
`define OP_SB    6'h28
`define OP_SH    6'h29
`define OP_SW    6'h2B
`define OP_LL    6'h30
`define OP_SC    6'h38
`define OP_CACHE 6'h2F

`endif

// File: common/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

    typedef enum logic [2:0] {
        MEM_BYTE = 3'd0,
        MEM_HALF = 3'd1,
        MEM_WORD = 3'd2
    } mem_size_e;

    // encoding matches what the cache controller expects on its instr port
    typedef enum logic [1:0] {
        CACHE_NONE      = 2'd0,
        CACHE_IDX_INV   = 2'd1,
        CACHE_STORE_TAG = 2'd2,
        CACHE_HIT_WB    = 2'd3
    } cache_op_e;

    typedef struct packed {
        logic             read;
        logic             write;
        mem_size_e        size;
        logic [3:0]       byte_en;
        logic [`XLEN-1:0] wdata;   // already replicated into its byte lanes
    } mem_op_t;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        logic [3:0]       byte_en;
        mem_size_e        size;
        logic             read;
        logic             write;
    } mem_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] rdata;
        logic             data_ok; // single cycle pulse
    } mem_resp_t;

    typedef struct packed {
        logic [`XLEN-1:0]     pc;
        logic [`REG_ID_W-1:0] reg_id;
        logic [`XLEN-1:0]     data;
        logic                 wen;
    } wb_rec_t;

    typedef struct packed {
        logic [`XLEN-1:0]     pc;
        logic [3:0]           wen;
        logic [`REG_ID_W-1:0] wnum;
        logic [`XLEN-1:0]     wdata;
    } debug_trace_t;

endpackage

// File: core_glue.f
+incdir+common
common/core_pkg.sv
design/reset_stretch.sv
design/cache_warmup.sv
mem_steer/mem_op_decode.sv
mem_steer/mem_req_router.sv
design/wb_trace.sv
design/core_glue_top.sv
verification/core_glue_tb.sv

// File: design/cache_warmup.sv
`include "core_macros.svh"

module cache_warmup (
    input  logic Clk,
    input  logic i_core_reset,
    input  logic i_inst_data_ok,
    input  logic i_dcache_close,
    output logic o_cache_bypass
);

    localparam int CNT_W = $clog2(`ICACHE_WARMUP_FETCHES + 1);

    logic [CNT_W-1:0] fetch_left;
    logic             icache_close;

    // the first fetches after reset go around the cache
    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            fetch_left <= CNT_W'(`ICACHE_WARMUP_FETCHES);
        end else if (i_inst_data_ok && fetch_left != '0) begin
            fetch_left <= fetch_left - 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            icache_close <= 1'b1;
        end else if (fetch_left == '0) begin
            icache_close <= 1'b0; // stays open until the next reset
        end
    end

    // cp0 may still close the data side at any time
    assign o_cache_bypass = icache_close | i_dcache_close;

endmodule

// File: design/core_glue_top.sv
`include "core_macros.svh"

module core_glue_top
    import core_pkg::*;
(
    input  logic             Clk,
    input  logic             Myreset,
    output logic             o_core_reset,

    input  logic             i_inst_data_ok,
    input  logic             i_dcache_close,
    output logic             o_cache_bypass,

    input  logic [`XLEN-1:0] i_instr,
    input  logic [`XLEN-1:0] i_ex_addr,
    input  logic [`XLEN-1:0] i_ex_wdata,
    input  logic             i_exception,

    input  mem_resp_t        i_cache_resp,
    input  mem_resp_t        i_uncached_resp,
    output mem_req_t         o_cached_req,
    output mem_req_t         o_uncached_req,
    output cache_op_e        o_cache_op,
    output logic [`XLEN-1:0] o_rdata,
    output logic             o_data_ok,

    input  wb_rec_t          i_wb,
    input  logic             i_mem_stall,
    input  logic             i_flush,
    output debug_trace_t     o_debug
);

    mem_op_t   ex_op;
    cache_op_e ex_cache_op;

    reset_stretch u_reset_stretch (
        .Clk          (Clk),
        .Myreset      (Myreset),
        .o_core_reset (o_core_reset)
    );

    cache_warmup u_cache_warmup (
        .Clk            (Clk),
        .i_core_reset   (o_core_reset),
        .i_inst_data_ok (i_inst_data_ok),
        .i_dcache_close (i_dcache_close),
        .o_cache_bypass (o_cache_bypass)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // execute stage memory path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    mem_op_decode u_mem_op_decode (
        .i_instr    (i_instr),
        .i_addr     (i_ex_addr),
        .i_wdata    (i_ex_wdata),
        .o_op       (ex_op),
        .o_cache_op (ex_cache_op)
    );

    mem_req_router u_mem_req_router (
        .i_op            (ex_op),
        .i_cache_op      (ex_cache_op),
        .i_addr          (i_ex_addr),
        .i_bypass        (o_cache_bypass),
        .i_exception     (i_exception),
        .i_cache_resp    (i_cache_resp),
        .i_uncached_resp (i_uncached_resp),
        .o_cached_req    (o_cached_req),
        .o_uncached_req  (o_uncached_req),
        .o_cache_op      (o_cache_op),
        .o_rdata         (o_rdata),
        .o_data_ok       (o_data_ok)
    );

    wb_trace u_wb_trace (
        .Clk          (Clk),
        .i_core_reset (o_core_reset),
        .i_wb         (i_wb),
        .i_mem_stall  (i_mem_stall),
        .i_exception  (i_exception),
        .i_flush      (i_flush),
        .o_debug      (o_debug)
    );

endmodule

// File: design/reset_stretch.sv
`include "core_macros.svh"

module reset_stretch (
    input  logic Clk,
    input  logic Myreset,
    output logic o_core_reset
);

    localparam int CNT_W = $clog2(`RESET_HOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(`RESET_HOLD_CYCLES);

    logic             held;
    logic [CNT_W-1:0] hold_cnt;

    // caches walk their sets while this is held, so the core must wait
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            held     <= 1'b1;
            hold_cnt <= '0;
        end else if (held) begin
            if (hold_cnt == HOLD_LAST) begin
                held <= 1'b0;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

    assign o_core_reset = Myreset | held; // external reset reaches the core at once

endmodule

// File: design/wb_trace.sv
module wb_trace
    import core_pkg::*;
(
    input  logic         Clk,
    input  logic         i_core_reset,
    input  wb_rec_t      i_wb,
    input  logic         i_mem_stall,
    input  logic         i_exception,
    input  logic         i_flush,
    output debug_trace_t o_debug
);

    wb_rec_t wb_q;
    logic    wen_live;

    // record holds while the memory stage is stalled
    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            wb_q <= '0;
        end else if (!i_mem_stall) begin
            wb_q <= i_wb;
        end
    end

    // a stalled record is only reported once, unless the exception retires it
    assign wen_live = wb_q.wen & (~i_mem_stall | i_exception);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // trace output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (i_flush) begin
            o_debug = '0; // flushed instructions never appear in the trace
        end else begin
            o_debug.pc    = wb_q.pc;
            o_debug.wen   = {4{wen_live}};
            o_debug.wnum  = wb_q.reg_id;
            o_debug.wdata = wb_q.data;
        end
    end

endmodule

// File: mem_steer/mem_op_decode.sv
`include "core_macros.svh"

module mem_op_decode
    import core_pkg::*;
(
    input  logic [`XLEN-1:0] i_instr,
    input  logic [`XLEN-1:0] i_addr,
    input  logic [`XLEN-1:0] i_wdata,
    output mem_op_t          o_op,
    output cache_op_e        o_cache_op
);

    logic [5:0] opcode;
    logic [2:0] rt_sel;   // rt bits 4 to 2 pick the CACHE operation
    logic [1:0] lane;
    logic [3:0] be_raw;

    assign opcode = i_instr[31:26];
    assign rt_sel = i_instr[20:18];
    assign lane   = i_addr[1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // size and direction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        o_op.read  = 1'b0;
        o_op.write = 1'b0;
        o_op.size  = MEM_BYTE;
        case (opcode)
            `OP_LB, `OP_LBU: o_op.read = 1'b1;
            `OP_LH, `OP_LHU: begin
                o_op.read = 1'b1;
                o_op.size = MEM_HALF;
            end
            `OP_LW, `OP_LL: begin
                o_op.read = 1'b1;
                o_op.size = MEM_WORD;
            end
            `OP_SB: o_op.write = 1'b1;
            `OP_SH: begin
                o_op.write = 1'b1;
                o_op.size  = MEM_HALF;
            end
            `OP_SW, `OP_SC: begin
                o_op.write = 1'b1;
                o_op.size  = MEM_WORD;
            end
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (o_op.size)
            MEM_WORD: begin
                be_raw     = 4'b1111;
                o_op.wdata = i_wdata;
            end
            MEM_HALF: begin
                be_raw     = lane[1] ? 4'b1100 : 4'b0011;
                o_op.wdata = {2{i_wdata[15:0]}};
            end
            default: begin
                be_raw     = 4'b0001 << lane;
                o_op.wdata = {4{i_wdata[7:0]}};
            end
        endcase
    end

    assign o_op.byte_en = o_op.write ? be_raw : 4'b0000; // loads read the whole word

    always_comb begin
        o_cache_op = CACHE_NONE;
        if (opcode == `OP_CACHE) begin
            case (rt_sel)
                3'b000:  o_cache_op = CACHE_IDX_INV;
                3'b010:  o_cache_op = CACHE_STORE_TAG;
                3'b110:  o_cache_op = CACHE_HIT_WB;
                default: o_cache_op = CACHE_NONE;
            endcase
        end
    end

endmodule

// File: mem_steer/mem_req_router.sv
`include "core_macros.svh"

module mem_req_router
    import core_pkg::*;
(
    input  mem_op_t          i_op,
    input  cache_op_e        i_cache_op,
    input  logic [`XLEN-1:0] i_addr,
    input  logic             i_bypass,
    input  logic             i_exception,
    input  mem_resp_t        i_cache_resp,
    input  mem_resp_t        i_uncached_resp,
    output mem_req_t         o_cached_req,
    output mem_req_t         o_uncached_req,
    output cache_op_e        o_cache_op,
    output logic [`XLEN-1:0] o_rdata,
    output logic             o_data_ok
);

    logic in_kseg1;
    logic uncached;
    logic rd_go;
    logic wr_go;

    assign in_kseg1 = (i_addr[`XLEN-1 -: 3] == `KSEG1_PREFIX);
    assign uncached = in_kseg1 | i_bypass;

    // an excepting instruction must not touch memory
    assign rd_go = i_op.read  & ~i_exception;
    assign wr_go = i_op.write & ~i_exception;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // requests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        o_cached_req.addr    = i_addr;
        o_cached_req.wdata   = i_op.wdata;
        o_cached_req.byte_en = i_op.byte_en;
        o_cached_req.size    = i_op.size;
        o_cached_req.read    = rd_go & ~uncached;
        o_cached_req.write   = wr_go & ~uncached;
    end

    always_comb begin
        o_uncached_req.addr    = i_addr;
        o_uncached_req.wdata   = i_op.wdata;
        o_uncached_req.byte_en = i_op.byte_en;
        o_uncached_req.size    = i_op.size;
        o_uncached_req.read    = rd_go & uncached;
        o_uncached_req.write   = wr_go & uncached;
    end

    assign o_cache_op = i_exception ? CACHE_NONE : i_cache_op;

    // response side follows the same address decision as the request
    always_comb begin
        if (uncached) begin
            o_rdata   = i_uncached_resp.rdata;
            o_data_ok = i_uncached_resp.data_ok;
        end else begin
            o_rdata   = i_cache_resp.rdata;
            o_data_ok = i_cache_resp.data_ok;
        end
    end

endmodule

// File: verification/core_glue_tb.sv
`include "core_macros.svh"

module core_glue_tb
    import core_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 600; // well above the length of the directed sequence
    localparam logic [5:0] MEM_OPS [10] = '{`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU,
                                            `OP_SB, `OP_SH, `OP_SW, `OP_LL, `OP_SC};

    // rt patterns for CACHE and the operation that each one selects
    localparam logic [11:0] CACHE_RT  = {3'b111, 3'b110, 3'b010, 3'b000};
    localparam logic [7:0]  CACHE_EXP = {CACHE_NONE, CACHE_HIT_WB, CACHE_STORE_TAG,
                                         CACHE_IDX_INV};

    logic             Clk, Myreset, o_core_reset;
    logic             i_inst_data_ok, i_dcache_close, o_cache_bypass;
    logic [`XLEN-1:0] i_instr, i_ex_addr, i_ex_wdata, o_rdata;
    logic             i_exception, o_data_ok, i_mem_stall, i_flush;
    mem_resp_t        i_cache_resp, i_uncached_resp;
    mem_req_t         o_cached_req, o_uncached_req;
    cache_op_e        o_cache_op;
    wb_rec_t          i_wb;
    debug_trace_t     o_debug;
    integer           seed;
    int               cycle_count = 0;
    int               err_count = 0;

    core_glue_top dut (.*);

    initial Clk = 1'b0;
    always #4 Clk = ~Clk;

    always @(posedge Clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_val(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        assert (got === exp) else begin
            err_count++;
            $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge Clk);
        #1; // inputs change just after the edge
    endtask

    task automatic settle_outputs();
        #1;
    endtask

    function automatic mem_size_e exp_size(input logic [5:0] opc);
        case (opc)
            `OP_LW, `OP_SW, `OP_LL, `OP_SC: return MEM_WORD;
            `OP_LH, `OP_LHU, `OP_SH:        return MEM_HALF;
            default:                         return MEM_BYTE;
        endcase
    endfunction

    // only stores drive byte enables
    function automatic logic [3:0] exp_byte_en(input mem_size_e size, input logic [1:0] lo,
                                               input logic is_wr);
        logic [3:0] be;
        for (int b = 0; b < 4; b++) begin
            case (size)
                MEM_WORD: be[b] = 1'b1;
                MEM_HALF: be[b] = (b[1] == lo[1]);
                default:  be[b] = (b[1:0] == lo);
            endcase
        end
        return is_wr ? be : 4'b0000;
    endfunction

    function automatic logic [`XLEN-1:0] exp_lanes(input mem_size_e size,
                                                   input logic [`XLEN-1:0] wdata);
        logic [`XLEN-1:0] lanes;
        for (int b = 0; b < 4; b++) begin
            case (size)
                MEM_WORD: lanes[8*b +: 8] = wdata[8*b +: 8];
                MEM_HALF: lanes[8*b +: 8] = wdata[8*(b%2) +: 8];
                default:  lanes[8*b +: 8] = wdata[7:0];
            endcase
        end
        return lanes;
    endfunction

    task automatic check_trace(input wb_rec_t rec, input logic [3:0] exp_wen);
        check_val("o_debug.pc", o_debug.pc, rec.pc);
        check_val("o_debug.wen", o_debug.wen, exp_wen);
        check_val("o_debug.wnum", o_debug.wnum, rec.reg_id);
        check_val("o_debug.wdata", o_debug.wdata, rec.data);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_stretch();
        for (int k = 1; k <= `RESET_HOLD_CYCLES; k++) begin
            next_cycle();
            check_val("o_core_reset", o_core_reset, 1'b1);
        end
        next_cycle();
        check_val("o_core_reset", o_core_reset, 1'b0);
    endtask

    task automatic test_cache_warmup();
        check_val("o_cache_bypass", o_cache_bypass, 1'b1);
        for (int p = 0; p < `ICACHE_WARMUP_FETCHES; p++) begin
            next_cycle();
            i_inst_data_ok = 1'b1;
            next_cycle(); // this edge counts the fetch
            i_inst_data_ok = 1'b0;
            settle_outputs();
            check_val("o_cache_bypass", o_cache_bypass, 1'b1);
        end
        next_cycle();
        check_val("o_cache_bypass", o_cache_bypass, 1'b0);
        i_dcache_close = 1'b1;
        settle_outputs();
        check_val("o_cache_bypass", o_cache_bypass, 1'b1);
        i_dcache_close = 1'b0;
        i_inst_data_ok = 1'b1; // later fetches leave caching on
        next_cycle();
        i_inst_data_ok = 1'b0;
        settle_outputs();
        check_val("o_cache_bypass", o_cache_bypass, 1'b0);
    endtask

    task automatic test_decode();
        mem_req_t         sel;
        mem_req_t         other;
        mem_size_e        size;
        logic [`XLEN-1:0] rnd;
        logic             is_wr;
        string            pname;
        for (int n = 0; n < 10; n++) begin
            for (int lo = 0; lo < 4; lo++) begin
                next_cycle();
                rnd        = $random(seed);
                i_instr    = {MEM_OPS[n], rnd[25:0]};
                i_ex_addr  = $random(seed);
                i_ex_addr[1:0] = lo[1:0];
                i_ex_wdata = $random(seed);
                settle_outputs();
                is_wr = MEM_OPS[n] inside {`OP_SB, `OP_SH, `OP_SW, `OP_SC};
                size  = exp_size(MEM_OPS[n]);
                if (i_ex_addr[`XLEN-1 -: 3] == `KSEG1_PREFIX) begin
                    sel   = o_uncached_req;
                    other = o_cached_req;
                    pname = "o_uncached_req";
                end else begin
                    sel   = o_cached_req;
                    other = o_uncached_req;
                    pname = "o_cached_req";
                end
                check_val({pname, ".read"}, sel.read, !is_wr);
                check_val({pname, ".write"}, sel.write, is_wr);
                check_val({pname, ".size"}, sel.size, size);
                check_val({pname, ".addr"}, sel.addr, i_ex_addr);
                check_val({pname, ".byte_en"}, sel.byte_en, exp_byte_en(size, lo[1:0], is_wr));
                check_val("other port size", other.size, size);
                check_val("other port addr", other.addr, i_ex_addr);
                check_val("other port byte_en", other.byte_en,
                          exp_byte_en(size, lo[1:0], is_wr));
                if (is_wr) begin
                    check_val({pname, ".wdata"}, sel.wdata, exp_lanes(size, i_ex_wdata));
                    check_val("other port wdata", other.wdata, exp_lanes(size, i_ex_wdata));
                end
                check_val("other port read", other.read, 1'b0);
                check_val("other port write", other.write, 1'b0);
                check_val("o_cache_op", o_cache_op, CACHE_NONE);
            end
        end
        // rt bits 4 to 2 of a CACHE instruction pick the operation
        for (int q = 0; q < 4; q++) begin
            next_cycle();
            rnd     = $random(seed);
            i_instr = {`OP_CACHE, rnd[25:21], CACHE_RT[3*q +: 3], rnd[17:0]};
            settle_outputs();
            check_val("o_cache_op", o_cache_op, CACHE_EXP[2*q +: 2]);
            check_val("strobes on CACHE", {o_cached_req.read, o_cached_req.write,
                      o_uncached_req.read, o_uncached_req.write}, 4'b0000);
        end
    endtask

    task automatic test_routing();
        logic [`XLEN-1:0] rnd;
        logic             to_unc;
        logic             exp_rd;
        logic             exp_wr;
        for (int i = 0; i < 16; i++) begin
            next_cycle();
            rnd            = $random(seed);
            i_instr        = {i[3] ? `OP_SW : `OP_LW, rnd[25:0]};
            i_ex_addr      = $random(seed);
            i_ex_addr[`XLEN-1 -: 3] = i[0] ? `KSEG1_PREFIX : 3'b100;
            i_dcache_close = i[1];
            i_exception    = i[2];
            i_cache_resp   = {32'($random(seed)), rnd[0]};
            i_uncached_resp = {32'($random(seed)), !rnd[0]};
            settle_outputs();
            to_unc = i[0] | i[1];
            exp_rd = !i[3] && !i[2];
            exp_wr = i[3] && !i[2];
            check_val("o_cached_req.read", o_cached_req.read, exp_rd && !to_unc);
            check_val("o_cached_req.write", o_cached_req.write, exp_wr && !to_unc);
            check_val("o_uncached_req.read", o_uncached_req.read, exp_rd && to_unc);
            check_val("o_uncached_req.write", o_uncached_req.write, exp_wr && to_unc);
            check_val("o_rdata", o_rdata,
                      to_unc ? i_uncached_resp.rdata : i_cache_resp.rdata);
            check_val("o_data_ok", o_data_ok,
                      to_unc ? i_uncached_resp.data_ok : i_cache_resp.data_ok);
        end
        next_cycle();
        i_instr = {`OP_CACHE, 5'd0, 3'b110, 18'd0};
        settle_outputs();
        check_val("o_cache_op", o_cache_op, CACHE_NONE); // exception still high
        i_exception = 1'b0;
        settle_outputs();
        check_val("o_cache_op", o_cache_op, CACHE_HIT_WB);
        i_dcache_close  = 1'b0;
        i_cache_resp    = '0;
        i_uncached_resp = '0;
    endtask

    task automatic test_wb_trace();
        wb_rec_t recs [3];
        for (int r = 0; r < 3; r++) begin
            recs[r] = {32'($random(seed)), 5'($random(seed)), 32'($random(seed)), r != 2};
        end
        next_cycle();
        check_trace('0, 4'h0);
        i_wb = recs[0];
        settle_outputs();
        check_trace('0, 4'h0);
        next_cycle();
        check_trace(recs[0], 4'hF);
        i_mem_stall = 1'b1;
        i_wb        = recs[1];
        settle_outputs();
        check_trace(recs[0], 4'h0);
        next_cycle();
        check_trace(recs[0], 4'h0);
        i_exception = 1'b1;
        settle_outputs();
        check_trace(recs[0], 4'hF);
        i_exception = 1'b0;
        i_mem_stall = 1'b0;
        settle_outputs();
        check_trace(recs[0], 4'hF);
        next_cycle();
        check_trace(recs[1], 4'hF);
        i_flush = 1'b1;
        settle_outputs();
        check_trace('0, 4'h0);
        i_flush = 1'b0;
        settle_outputs();
        check_trace(recs[1], 4'hF);
        i_wb = recs[2];
        next_cycle();
        check_trace(recs[2], 4'h0);
    endtask

    initial begin
        seed            = 80;
        Myreset         = 1'b1;
        i_inst_data_ok  = 1'b0;
        i_dcache_close  = 1'b0;
        i_instr         = '0;
        i_ex_addr       = '0;
        i_ex_wdata      = '0;
        i_exception     = 1'b0;
        i_cache_resp    = '0;
        i_uncached_resp = '0;
        i_wb            = '0;
        i_mem_stall     = 1'b0;
        i_flush         = 1'b0;
        repeat (2) @(posedge Clk);
        #1;
        check_val("o_core_reset", o_core_reset, 1'b1);
        Myreset = 1'b0;
        test_reset_stretch();
        test_cache_warmup();
        test_decode();
        test_routing();
        test_wb_trace();
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
